/* source/rob_cfg_pkg.sv */
// Sizes are fixed at 16 buffer entries and 16 registers; tag and index widths must stay in step
`default_nettype none

package rob_cfg_pkg;

    // Reorder buffer geometry
    // The tag indexes the buffer directly, so the depth must be a power of two
    localparam int ROB_DEPTH = 16;
    localparam int ROB_TAG_W = 4;

    // One extra bit lets the occupancy count reach the full depth
    localparam int ROB_CNT_W = ROB_TAG_W + 1;

    // Architectural register file
    localparam int NUM_AREGS = 16;
    localparam int AREG_W    = 4;

    // Data and address width
    // A branch target travels in the data field
    localparam int DATA_W = 32;

    // Number of source operands per instruction
    localparam int NUM_SRCS = 2;

endpackage

`default_nettype wire

/* source/rob_types_pkg.sv */
// Records exchanged between the rename table, the buffer and the register file; OP_NOP writes no register
`default_nettype none

package rob_types_pkg;
    import rob_cfg_pkg::*;

    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_NOP    = 2'd2
    } rob_op_e;

    // One instruction from the dispatcher
    typedef struct packed {
        rob_op_e           op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [DATA_W-1:0] pc;
    } disp_req_t;

    // A source as seen by the rename table
    typedef struct packed {
        logic                 pending;
        logic [ROB_TAG_W-1:0] tag;
    } src_lookup_t;

    typedef struct packed {
        logic                 ready;
        logic [ROB_TAG_W-1:0] tag;
        logic [DATA_W-1:0]    data;
    } src_result_t;

    // Both resolved sources and the tag handed to the new instruction
    typedef struct packed {
        src_result_t [NUM_SRCS-1:0] src;
        logic [ROB_TAG_W-1:0]       dst_tag;
    } opnd_t;

    // Completion bus record
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [DATA_W-1:0]    data;
        logic                 redirect;
    } cdb_t;

    typedef struct packed {
        logic                 valid;
        rob_op_e              op;
        logic [AREG_W-1:0]    rd;
        logic [ROB_TAG_W-1:0] tag;
        logic [DATA_W-1:0]    data;
    } retire_t;

endpackage

`default_nettype wire

/* source/rename_table.sv */
// Dispatch must not strobe while i_flush is high; operands are combinational in the dispatch cycle
`timescale 1ns/1ps
`default_nettype none

module rename_table
    import rob_cfg_pkg::*, rob_types_pkg::*;
(
    input  wire                              clk,
    input  wire                              i_rst_n,

    // Dispatch side
    input  wire                              i_disp_valid,
    input  disp_req_t                        i_disp,
    input  wire  [ROB_TAG_W-1:0]             i_new_tag,

    // Flush level from the buffer and head retirement
    input  wire                              i_flush,
    input  retire_t                          i_retire,

    // Source lookup through the buffer
    output src_lookup_t [NUM_SRCS-1:0]       o_lookup,
    input  src_result_t [NUM_SRCS-1:0]       i_lookup_res,

    // Committed values from the register file
    input  wire  [NUM_SRCS-1:0][DATA_W-1:0]  i_rf_data,

    output opnd_t                            o_opnd
);

    // A register is pending while a younger in-flight instruction will write it
    logic [NUM_AREGS-1:0] pend_q;
    logic [ROB_TAG_W-1:0] tag_q [NUM_AREGS];

    logic disp_map;
    logic ret_clear;
    logic [NUM_SRCS-1:0][AREG_W-1:0] src_idx;

    // An OP_NOP has no destination and so never takes a mapping
    assign disp_map = i_disp_valid && !i_flush && (i_disp.op != OP_NOP);

    // Only the instruction that still owns the mapping may release it
    assign ret_clear = i_retire.valid && (i_retire.op != OP_NOP) &&
                       pend_q[i_retire.rd] && (tag_q[i_retire.rd] == i_retire.tag);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pend_q <= '0;
        end else if (i_flush) begin
            // Everything still mapped is younger than the redirecting branch
            pend_q <= '0;
        end else begin
            if (ret_clear) begin
                pend_q[i_retire.rd] <= 1'b0;
            end
            // A dispatch to the same register overrides the release above
            if (disp_map) begin
                pend_q[i_disp.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_map) begin
            tag_q[i_disp.rd] <= i_new_tag;
        end
    end

    assign src_idx[0] = i_disp.rs1;
    assign src_idx[1] = i_disp.rs2;

    // Sources read the mapping as it was before this dispatch writes it
    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            o_lookup[s].pending = pend_q[src_idx[s]];
            o_lookup[s].tag     = tag_q[src_idx[s]];

            if (pend_q[src_idx[s]]) begin
                o_opnd.src[s] = i_lookup_res[s];
            end else begin
                o_opnd.src[s].ready = 1'b1;
                o_opnd.src[s].tag   = tag_q[src_idx[s]];
                o_opnd.src[s].data  = i_rf_data[s];
            end
        end
        o_opnd.dst_tag = i_new_tag;
    end

    // The cycle after a redirect belongs to the flush
    a_no_disp_in_flush: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_flush |-> !i_disp_valid
    ) else $error("dispatch strobed during a redirect flush");

endmodule

`default_nettype wire

/* source/rob_queue.sv */
// No back-pressure beyond o_rob_full; each tag completes at most once and only while allocated
`timescale 1ns/1ps
`default_nettype none

module rob_queue
    import rob_cfg_pkg::*, rob_types_pkg::*;
(
    input  wire                          clk,
    input  wire                          i_rst_n,

    // Dispatch allocates at the tail
    input  wire                          i_disp_valid,
    input  disp_req_t                    i_disp,

    // Single completion port
    input  cdb_t                         i_cdb,

    // Source lookup for the rename table
    input  src_lookup_t [NUM_SRCS-1:0]   i_lookup,
    output src_result_t [NUM_SRCS-1:0]   o_lookup_res,

    output logic [ROB_TAG_W-1:0]         o_tail_tag,
    output retire_t                      o_head_retire,
    output retire_t                      o_retire,
    output logic                         o_flush,
    output logic                         o_redirect,
    output logic [DATA_W-1:0]            o_redirect_pc,
    output logic                         o_rob_full
);

    logic [ROB_TAG_W-1:0] head_q;
    logic [ROB_TAG_W-1:0] tail_q;
    logic [ROB_CNT_W-1:0] count_q;

    // Per-entry state
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] redir_q;
    rob_op_e              op_q   [ROB_DEPTH];
    logic [AREG_W-1:0]    rd_q   [ROB_DEPTH];
    logic [DATA_W-1:0]    data_q [ROB_DEPTH];

    logic redirect_q;
    logic [DATA_W-1:0] redirect_pc_q;
    retire_t retire_q;

    logic disp_en;
    logic cdb_en;
    logic retire_en;
    logic [ROB_TAG_W-1:0] cdb_offset;

    // Nothing is accepted while the registered redirect flushes the buffer
    assign disp_en   = i_disp_valid && !redirect_q;
    assign cdb_en    = i_cdb.valid && !redirect_q;
    assign retire_en = (count_q != '0) && done_q[head_q] && !redirect_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (redirect_q) begin
            // The branch has already advanced the head, so the next tag follows it
            tail_q  <= head_q;
            count_q <= '0;
        end else begin
            if (disp_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_en) begin
                head_q <= head_q + 1'b1;
            end
            if (disp_en && !retire_en) begin
                count_q <= count_q + 1'b1;
            end else if (!disp_en && retire_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            done_q  <= '0;
            redir_q <= '0;
        end else begin
            if (disp_en) begin
                done_q[tail_q]  <= 1'b0;
                redir_q[tail_q] <= 1'b0;
            end
            if (cdb_en) begin
                done_q[i_cdb.tag]  <= 1'b1;
                redir_q[i_cdb.tag] <= i_cdb.redirect;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_en) begin
            op_q[tail_q] <= i_disp.op;
            rd_q[tail_q] <= i_disp.rd;
        end
        if (cdb_en) begin
            data_q[i_cdb.tag] <= i_cdb.data;
        end
    end

    // The head commits in the cycle it is found done
    always_comb begin
        o_head_retire.valid = retire_en;
        o_head_retire.op    = op_q[head_q];
        o_head_retire.rd    = rd_q[head_q];
        o_head_retire.tag   = head_q;
        o_head_retire.data  = data_q[head_q];
    end

    always_ff @(posedge clk) begin
        retire_q <= o_head_retire;
        if (!i_rst_n) begin
            retire_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= retire_en && redir_q[head_q];
        end
    end

    // For a branch the completion data is the target
    always_ff @(posedge clk) begin
        redirect_pc_q <= data_q[head_q];
    end

    // Lookups see a completion on the bus in the same cycle
    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            o_lookup_res[s].tag = i_lookup[s].tag;
            if (i_cdb.valid && (i_cdb.tag == i_lookup[s].tag)) begin
                o_lookup_res[s].ready = i_lookup[s].pending;
                o_lookup_res[s].data  = i_cdb.data;
            end else begin
                o_lookup_res[s].ready = i_lookup[s].pending && done_q[i_lookup[s].tag];
                o_lookup_res[s].data  = data_q[i_lookup[s].tag];
            end
        end
    end

    assign o_tail_tag    = tail_q;
    assign o_retire      = retire_q;
    assign o_flush       = redirect_q;
    assign o_redirect    = redirect_q;
    assign o_redirect_pc = redirect_pc_q;
    assign o_rob_full    = (count_q == ROB_CNT_W'(ROB_DEPTH));

    // Distance of the completing tag from the head
    assign cdb_offset = i_cdb.tag - head_q;

    a_no_disp_when_full: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_disp_valid |-> !o_rob_full
    ) else $error("dispatch while the buffer is full");

    a_cdb_tag_allocated: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_cdb.valid |-> (ROB_CNT_W'(cdb_offset) < count_q)
    ) else $error("completion for a tag that is not allocated");

    a_redirect_single: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_redirect |=> !o_redirect
    ) else $error("redirect held for two cycles");

endmodule

`default_nettype wire

/* source/arch_regfile.sv */
// Reads do not see a write in the same cycle; the rename table forwards that value instead
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
    import rob_cfg_pkg::*, rob_types_pkg::*;
(
    input  wire                              clk,
    input  wire                              i_rst_n,

    // Retirement from the buffer head
    input  retire_t                          i_retire,

    // Two combinational read ports
    input  wire  [NUM_SRCS-1:0][AREG_W-1:0]  i_rd_idx,
    output logic [NUM_SRCS-1:0][DATA_W-1:0]  o_rd_data
);

    logic [DATA_W-1:0] regs_q [NUM_AREGS];

    logic wr_en;

    // Every retiring instruction except OP_NOP has a destination
    assign wr_en = i_retire.valid && (i_retire.op != OP_NOP);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < NUM_AREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wr_en) begin
            regs_q[i_retire.rd] <= i_retire.data;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_SRCS; p++) begin
            o_rd_data[p] = regs_q[i_rd_idx[p]];
        end
    end

endmodule

`default_nettype wire

/* source/rob_core_top.sv */
// Single completion port and no memory side; dispatch is held off by o_rob_full and by the redirect cycle
`timescale 1ns/1ps
`default_nettype none

module rob_core_top
    import rob_cfg_pkg::*, rob_types_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst_n,

    input  wire                i_disp_valid,
    input  disp_req_t          i_disp,
    input  cdb_t               i_cdb,

    output opnd_t              o_opnd,
    output logic               o_rob_full,
    output retire_t            o_retire,
    output logic               o_redirect,
    output logic [DATA_W-1:0]  o_redirect_pc
);

    src_lookup_t [NUM_SRCS-1:0]      lookup;
    src_result_t [NUM_SRCS-1:0]      lookup_res;
    logic [NUM_SRCS-1:0][AREG_W-1:0] rd_idx;
    logic [NUM_SRCS-1:0][DATA_W-1:0] rf_data;
    logic [ROB_TAG_W-1:0]            tail_tag;
    retire_t                         head_retire;
    logic                            flush;

    // The register file is read with the raw source indices
    assign rd_idx[0] = i_disp.rs1;
    assign rd_idx[1] = i_disp.rs2;

    rename_table rename_table_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_disp_valid (i_disp_valid),
        .i_disp       (i_disp),
        .i_new_tag    (tail_tag),
        .i_flush      (flush),
        .i_retire     (head_retire),
        .o_lookup     (lookup),
        .i_lookup_res (lookup_res),
        .i_rf_data    (rf_data),
        .o_opnd       (o_opnd)
    );

    rob_queue rob_queue_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_disp_valid  (i_disp_valid),
        .i_disp        (i_disp),
        .i_cdb         (i_cdb),
        .i_lookup      (lookup),
        .o_lookup_res  (lookup_res),
        .o_tail_tag    (tail_tag),
        .o_head_retire (head_retire),
        .o_retire      (o_retire),
        .o_flush       (flush),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_rob_full    (o_rob_full)
    );

    arch_regfile arch_regfile_i (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_retire  (head_retire),
        .i_rd_idx  (rd_idx),
        .o_rd_data (rf_data)
    );

endmodule

`default_nettype wire

/* test/tb_rob_core.sv */
// Needs concurrent assertion support; traffic is random from seed 25 plus one directed redirect
`timescale 1ns/1ps
`default_nettype none

module tb_rob_core
    import rob_cfg_pkg::*, rob_types_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic              clk;
    logic              i_rst_n;
    logic              i_disp_valid;
    disp_req_t         i_disp;
    cdb_t              i_cdb;
    opnd_t             o_opnd;
    logic              o_rob_full;
    retire_t           o_retire;
    logic              o_redirect;
    logic [DATA_W-1:0] o_redirect_pc;

    int errors = 0;
    int timeouts = 0;

    // Reference model, in-flight tags run from m_head for m_cnt entries
    logic [ROB_TAG_W-1:0] m_head;
    logic [ROB_CNT_W-1:0] m_cnt;
    logic [ROB_TAG_W-1:0] m_tail;
    logic [ROB_DEPTH-1:0] m_done;
    logic [ROB_DEPTH-1:0] m_redir;
    rob_op_e              m_op   [ROB_DEPTH];
    logic [AREG_W-1:0]    m_rd   [ROB_DEPTH];
    logic [DATA_W-1:0]    m_data [ROB_DEPTH];
    logic [DATA_W-1:0]    m_rf   [NUM_AREGS];
    retire_t              m_ret;
    logic                 m_flush;
    logic [DATA_W-1:0]    m_flush_pc;
    logic                 retire_now;
    logic                 redir_now;

    logic [NUM_SRCS-1:0]             exp_ready;
    logic [NUM_SRCS-1:0]             exp_pend;
    logic [NUM_SRCS-1:0][ROB_TAG_W-1:0] exp_tag;
    logic [NUM_SRCS-1:0][DATA_W-1:0] exp_data;

    rob_core_top rob_core_top_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_disp_valid  (i_disp_valid),
        .i_disp        (i_disp),
        .i_cdb         (i_cdb),
        .o_opnd        (o_opnd),
        .o_rob_full    (o_rob_full),
        .o_retire      (o_retire),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign m_tail     = m_head + m_cnt[ROB_TAG_W-1:0];
    assign retire_now = (m_cnt != '0) && m_done[m_head];
    assign redir_now  = retire_now && m_redir[m_head];

    always @(posedge clk) begin
        if (!i_rst_n) begin
            m_head  <= '0;
            m_cnt   <= '0;
            m_done  <= '0;
            m_redir <= '0;
            m_flush <= 1'b0;
            m_ret   <= '0;
            for (int r = 0; r < NUM_AREGS; r++) begin
                m_rf[r] <= '0;
            end
        end else begin
            m_flush       <= redir_now;
            m_flush_pc    <= m_data[m_head];
            m_ret.valid   <= retire_now;
            m_ret.op      <= m_op[m_head];
            m_ret.rd      <= m_rd[m_head];
            m_ret.tag     <= m_head;
            m_ret.data    <= m_data[m_head];
            if (retire_now && (m_op[m_head] != OP_NOP)) begin
                m_rf[m_rd[m_head]] <= m_data[m_head];
            end
            if (i_cdb.valid) begin
                m_done[i_cdb.tag]  <= 1'b1;
                m_redir[i_cdb.tag] <= i_cdb.redirect;
                m_data[i_cdb.tag]  <= i_cdb.data;
            end
            if (i_disp_valid) begin
                m_done[m_tail]  <= 1'b0;
                m_redir[m_tail] <= 1'b0;
                m_op[m_tail]    <= i_disp.op;
                m_rd[m_tail]    <= i_disp.rd;
            end
            // A redirecting branch drops every younger instruction at once
            if (redir_now) begin
                m_head <= m_head + 1'b1;
                m_cnt  <= '0;
            end else begin
                if (retire_now) begin
                    m_head <= m_head + 1'b1;
                end
                m_cnt <= m_cnt + ROB_CNT_W'(i_disp_valid) - ROB_CNT_W'(retire_now);
            end
        end
    end

    // Expected operands come from the youngest in-flight writer, else the register file
    always_comb begin
        logic                 found;
        logic [ROB_TAG_W-1:0] t;
        logic [ROB_TAG_W-1:0] ptag;
        logic [AREG_W-1:0]    r;
        for (int s = 0; s < NUM_SRCS; s++) begin
            r     = (s == 0) ? i_disp.rs1 : i_disp.rs2;
            found = 1'b0;
            ptag  = '0;
            for (int k = 0; k < ROB_DEPTH; k++) begin
                t = m_head + ROB_TAG_W'(k);
                if ((k < int'(m_cnt)) && (m_op[t] != OP_NOP) && (m_rd[t] == r)) begin
                    found = 1'b1;
                    ptag  = t;
                end
            end
            exp_pend[s]  = found;
            exp_tag[s]   = ptag;
            exp_ready[s] = 1'b1;
            exp_data[s]  = '0;
            if (!found) begin
                exp_data[s] = m_rf[r];
            end else if (m_done[ptag]) begin
                exp_data[s] = m_data[ptag];
            end else if (i_cdb.valid && (i_cdb.tag == ptag)) begin
                exp_data[s] = i_cdb.data;
            end else begin
                exp_ready[s] = 1'b0;
            end
        end
    end

    a_dst_tag: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_disp_valid |-> (o_opnd.dst_tag == m_tail))
    else begin
        errors++;
        $display("[ERROR] o_opnd.dst_tag: got %h, expected %h",
                 $sampled(o_opnd.dst_tag), $sampled(m_tail));
    end

    // The count is stale while the flush is in progress
    a_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        !m_flush |-> (o_rob_full == (m_cnt == ROB_CNT_W'(ROB_DEPTH))))
    else begin
        errors++;
        $display("[ERROR] o_rob_full: got %h, expected %h", $sampled(o_rob_full),
                 $sampled(m_cnt == ROB_CNT_W'(ROB_DEPTH)));
    end

    for (genvar s = 0; s < NUM_SRCS; s++) begin : g_src
        a_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
            i_disp_valid |-> (o_opnd.src[s].ready == exp_ready[s]))
        else begin
            errors++;
            $display("[ERROR] o_opnd.src[%0d].ready: got %h, expected %h", s,
                     $sampled(o_opnd.src[s].ready), $sampled(exp_ready[s]));
        end

        a_data: assert property (@(posedge clk) disable iff (!i_rst_n)
            (i_disp_valid && exp_ready[s]) |-> (o_opnd.src[s].data == exp_data[s]))
        else begin
            errors++;
            $display("[ERROR] o_opnd.src[%0d].data: got %h, expected %h", s,
                     $sampled(o_opnd.src[s].data), $sampled(exp_data[s]));
        end

        // A source with an in-flight writer names that writer's tag
        a_tag: assert property (@(posedge clk) disable iff (!i_rst_n)
            (i_disp_valid && exp_pend[s]) |-> (o_opnd.src[s].tag == exp_tag[s]))
        else begin
            errors++;
            $display("[ERROR] o_opnd.src[%0d].tag: got %h, expected %h", s,
                     $sampled(o_opnd.src[s].tag), $sampled(exp_tag[s]));
        end
    end

    a_retire_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_retire.valid == m_ret.valid)
    else begin
        errors++;
        $display("[ERROR] o_retire.valid: got %h, expected %h",
                 $sampled(o_retire.valid), $sampled(m_ret.valid));
    end

    a_retire_rec: assert property (@(posedge clk) disable iff (!i_rst_n)
        m_ret.valid |-> (o_retire == m_ret))
    else begin
        errors++;
        $display("[ERROR] o_retire: got %h, expected %h", $sampled(o_retire), $sampled(m_ret));
    end

    a_redirect: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_redirect == m_flush)
    else begin
        errors++;
        $display("[ERROR] o_redirect: got %h, expected %h",
                 $sampled(o_redirect), $sampled(m_flush));
    end

    a_redirect_pc: assert property (@(posedge clk) disable iff (!i_rst_n)
        m_flush |-> (o_redirect_pc == m_flush_pc))
    else begin
        errors++;
        $display("[ERROR] o_redirect_pc: got %h, expected %h",
                 $sampled(o_redirect_pc), $sampled(m_flush_pc));
    end

    function automatic disp_req_t make_req(input rob_op_e op, input int rd,
                                           input int rs1, input int rs2);
        disp_req_t req;
        req.op  = op;
        req.rd  = AREG_W'(rd);
        req.rs1 = AREG_W'(rs1);
        req.rs2 = AREG_W'(rs2);
        req.pc  = $urandom;
        return req;
    endfunction

    function automatic cdb_t make_cmp(input logic [ROB_TAG_W-1:0] tag,
                                      input logic [DATA_W-1:0] data, input logic redir);
        cdb_t cmp;
        cmp.valid    = 1'b1;
        cmp.tag      = tag;
        cmp.data     = data;
        cmp.redirect = redir;
        return cmp;
    endfunction

    // Something is still in flight or about to be
    function automatic logic busy();
        return (m_cnt != '0) || i_disp_valid || m_flush;
    endfunction

    task automatic directed_cycle(input logic dv, input disp_req_t req, input cdb_t cmp);
        @(posedge clk);
        i_disp_valid <= dv;
        i_disp       <= req;
        i_cdb        <= cmp;
    endtask

    task automatic random_cycle(input logic disp_on, input logic cmp_on);
        disp_req_t            req;
        cdb_t                 cmp;
        logic                 dv;
        logic [ROB_TAG_W-1:0] cand [$];
        logic [ROB_TAG_W-1:0] t;
        int                   next_cnt;
        int                   sel;
        @(posedge clk);
        req      = '0;
        cmp      = '0;
        dv       = 1'b0;
        next_cnt = int'(m_cnt) + int'(i_disp_valid) - int'(retire_now);
        // The cycle after a redirecting retire takes no traffic at all
        if (!redir_now) begin
            if (disp_on && (next_cnt < ROB_DEPTH) && ($urandom % 2 == 1)) begin
                sel = $urandom % 8;
                req = make_req(OP_ALU, $urandom % 16, $urandom % 16, $urandom % 16);
                if (sel == 0) begin
                    req.op = OP_NOP;
                end else if (sel < 3) begin
                    req.op = OP_BRANCH;
                end
                dv = 1'b1;
            end
            for (int k = 0; k < ROB_DEPTH; k++) begin
                t = m_head + ROB_TAG_W'(k);
                if ((k < int'(m_cnt)) && !m_done[t] && !(i_cdb.valid && (i_cdb.tag == t))) begin
                    cand.push_back(t);
                end
            end
            if (cmp_on && (cand.size() > 0) && ($urandom % 2 == 1)) begin
                t   = cand[$urandom % cand.size()];
                cmp = make_cmp(t, $urandom, (m_op[t] == OP_BRANCH) && ($urandom % 4 == 0));
            end
        end
        i_disp_valid <= dv;
        i_disp       <= req;
        i_cdb        <= cmp;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (busy() && (n < TIMEOUT)) begin
            random_cycle(1'b0, 1'b1);
            n++;
        end
        if (busy()) begin
            timeouts++;
            $display("Timeout: the buffer did not drain within %0d cycles", TIMEOUT);
        end
    endtask

    initial begin
        logic [ROB_TAG_W-1:0] br_tag;
        int                   n;
        void'($urandom(25));
        i_rst_n      = 1'b0;
        i_disp_valid = 1'b0;
        i_disp       = '0;
        i_cdb        = '0;
        repeat (16) @(posedge clk);
        i_rst_n <= 1'b1;

        // A burst with no completions runs into the full level
        n = 0;
        while ((m_cnt != ROB_CNT_W'(ROB_DEPTH)) && (n < TIMEOUT)) begin
            random_cycle(1'b1, 1'b0);
            n++;
        end
        if (m_cnt != ROB_CNT_W'(ROB_DEPTH)) begin
            timeouts++;
            $display("Timeout: the buffer never filled during the dispatch burst");
        end
        repeat (4) random_cycle(1'b1, 1'b0);
        drain();

        repeat (800) random_cycle(1'b1, 1'b1);
        drain();

        // Younger writers complete first and the branch flushes them
        br_tag = m_tail;
        directed_cycle(1'b1, make_req(OP_BRANCH, 1, 2, 3), '0);
        directed_cycle(1'b1, make_req(OP_ALU, 7, 1, 0), '0);
        directed_cycle(1'b1, make_req(OP_ALU, 8, 7, 7), '0);
        directed_cycle(1'b0, '0, make_cmp(br_tag + 1'b1, 32'h1111_7777, 1'b0));
        directed_cycle(1'b0, '0, make_cmp(br_tag + 2'd2, 32'h2222_8888, 1'b0));
        directed_cycle(1'b0, '0, make_cmp(br_tag, 32'h0000_4000, 1'b1));
        n = 0;
        while (!m_flush && (n < TIMEOUT)) begin
            directed_cycle(1'b0, '0, '0);
            n++;
        end
        if (!m_flush) begin
            timeouts++;
            $display("Timeout: no redirect after the branch completed");
        end
        directed_cycle(1'b1, make_req(OP_ALU, 9, 7, 8), '0);
        directed_cycle(1'b1, make_req(OP_NOP, 7, 1, 9), '0);
        drain();
        directed_cycle(1'b1, make_req(OP_ALU, 10, 7, 9), '0);
        drain();
        repeat (3) directed_cycle(1'b0, '0, '0);

        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/rob_cfg_pkg.sv
source/rob_types_pkg.sv
source/rename_table.sv
source/rob_queue.sv
source/arch_regfile.sv
source/rob_core_top.sv
test/tb_rob_core.sv

/* Makefile */
# Verilator flow for the reorder buffer testbench
TOP := tb_rob_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
